// File: rst_ctrl_pkg.sv
// Shared register offsets, AXI response codes and command types used by the reset controller
`default_nettype none

package rst_ctrl_pkg;

    // Word offsets taken from address bits 3..2
    localparam logic [1:0] offset_load  = 2'd0;
    localparam logic [1:0] offset_set   = 2'd1;
    localparam logic [1:0] offset_clear = 2'd2;
    localparam logic [1:0] offset_bad   = 2'd3;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Operation applied to the reset register
    typedef enum logic [1:0] {
        op_load  = 2'd0,
        op_set   = 2'd1,
        op_clear = 2'd2,
        op_none  = 2'd3
    } reg_op_t;

    // One decoded write, valid for a single cycle
    typedef struct packed {
        logic        valid;
        reg_op_t     op;
        logic [31:0] data;
    } reg_cmd_t;

endpackage

`default_nettype wire

// File: rst_ctrl_axi_wr.sv
// AXI4-Lite write channel that decodes each write into a register command and a B response
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_axi_wr (
    input  wire                       s_axi_aclk,
    input  wire                       s_axi_aresetn,
    input  wire [31:0]                awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire [31:0]                wdata,
    input  wire                       wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire                       bready,
    output rst_ctrl_pkg::reg_cmd_t    cmd
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_data,
        st_respond
    } wr_state_t;

    wr_state_t            state;
    logic [1:0]           off_q;
    logic [31:0]          data_q;
    logic                 data_held;
    logic                 cmd_valid;
    logic                 aw_hs;
    logic                 w_hs;
    rst_ctrl_pkg::reg_op_t cmd_op;

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state     <= st_idle;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            cmd_valid <= 1'b0;
            data_held <= 1'b0;
            off_q     <= rst_ctrl_pkg::offset_load;
        end else begin
            // Command is a single-cycle strobe
            cmd_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (aw_hs) begin
                        off_q   <= awaddr[3:2];
                        awready <= 1'b0;
                        if (w_hs || data_held) begin
                            wready    <= 1'b0;
                            bvalid    <= 1'b1;
                            cmd_valid <= 1'b1;
                            data_held <= 1'b0;
                            state     <= st_respond;
                        end else begin
                            wready <= 1'b1;
                            state  <= st_wait_data;
                        end
                    end else if (w_hs) begin
                        // Data came first, park it until the address shows up
                        data_held <= 1'b1;
                        wready    <= 1'b0;
                        awready   <= 1'b1;
                    end else begin
                        awready <= 1'b1;
                        wready  <= ~data_held;
                    end
                end
                st_wait_data: begin
                    if (w_hs) begin
                        wready    <= 1'b0;
                        bvalid    <= 1'b1;
                        cmd_valid <= 1'b1;
                        state     <= st_respond;
                    end
                end
                st_respond: begin
                    // Hold B until the master takes it
                    if (bready) begin
                        bvalid  <= 1'b0;
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Write payload
    always_ff @(posedge s_axi_aclk) begin
        if (w_hs) begin
            data_q <= wdata;
        end
    end

    always_comb begin
        case (off_q)
            rst_ctrl_pkg::offset_load:  cmd_op = rst_ctrl_pkg::op_load;
            rst_ctrl_pkg::offset_set:   cmd_op = rst_ctrl_pkg::op_set;
            rst_ctrl_pkg::offset_clear: cmd_op = rst_ctrl_pkg::op_clear;
            default:                    cmd_op = rst_ctrl_pkg::op_none;
        endcase
    end

    // Offset 3 is not a register and answers with an error
    assign bresp = (off_q == rst_ctrl_pkg::offset_bad) ? rst_ctrl_pkg::resp_slverr
                                                       : rst_ctrl_pkg::resp_okay;

    assign cmd.valid = cmd_valid;
    assign cmd.op    = cmd_op;
    assign cmd.data  = data_q;

endmodule

`default_nettype wire

// File: rst_ctrl_reg.sv
// Reset register that applies load, set and clear commands and drives the reset lines
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_reg #(
    parameter int NUM_RESETS = 8
) (
    input  wire                       s_axi_aclk,
    input  wire                       s_axi_aresetn,
    input  wire rst_ctrl_pkg::reg_cmd_t cmd,
    output logic [NUM_RESETS-1:0]     reg_value
);

    logic [NUM_RESETS-1:0] cmd_bits;

    // Only the low data bits reach the register
    assign cmd_bits = cmd.data[NUM_RESETS-1:0];

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            reg_value <= '0;
        end else if (cmd.valid) begin
            case (cmd.op)
                rst_ctrl_pkg::op_load:  reg_value <= cmd_bits;
                rst_ctrl_pkg::op_set:   reg_value <= reg_value | cmd_bits;
                rst_ctrl_pkg::op_clear: reg_value <= reg_value & ~cmd_bits;
                default:                reg_value <= reg_value;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rst_ctrl_axi_rd.sv
// AXI4-Lite read channel that returns the reset register on every read address
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_axi_rd #(
    parameter int NUM_RESETS = 8
) (
    input  wire                   s_axi_aclk,
    input  wire                   s_axi_aresetn,
    input  wire                   arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  wire                   rready,
    input  wire [NUM_RESETS-1:0]  reg_value
);

    typedef enum logic {
        rd_idle,
        rd_respond
    } rd_state_t;

    rd_state_t state;
    logic      ar_hs;

    assign ar_hs = arvalid & arready;

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state   <= rd_idle;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            case (state)
                rd_idle: begin
                    arready <= 1'b1;
                    if (ar_hs) begin
                        arready <= 1'b0;
                        rvalid  <= 1'b1;
                        state   <= rd_respond;
                    end
                end
                rd_respond: begin
                    // Ready for the next address as soon as R completes
                    if (rready) begin
                        rvalid  <= 1'b0;
                        arready <= 1'b1;
                        state   <= rd_idle;
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // Snapshot taken at acceptance, zero-extended to the bus width
    always_ff @(posedge s_axi_aclk) begin
        if (ar_hs) begin
            rdata <= 32'(reg_value);
        end
    end

    assign rresp = rst_ctrl_pkg::resp_okay;

endmodule

`default_nettype wire

// File: rst_ctrl_top.sv
// Top level of the memory-mapped reset controller with an AXI4-Lite slave port
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_top #(
    parameter int NUM_RESETS = 8
) (
    input  wire                   s_axi_aclk,
    input  wire                   s_axi_aresetn,
    input  wire [31:0]            s_axi_awaddr,
    input  wire                   s_axi_awvalid,
    output logic                  s_axi_awready,
    input  wire [31:0]            s_axi_wdata,
    input  wire [3:0]             s_axi_wstrb,
    input  wire                   s_axi_wvalid,
    output logic                  s_axi_wready,
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  wire                   s_axi_bready,
    input  wire [31:0]            s_axi_araddr,
    input  wire                   s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [31:0]           s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  wire                   s_axi_rready,
    output logic [NUM_RESETS-1:0] reset_out
);

    // s_axi_wstrb and s_axi_araddr are unused
    // Whole data words are written and every address reads the one register

    rst_ctrl_pkg::reg_cmd_t cmd;
    logic [NUM_RESETS-1:0]  reg_value;

    rst_ctrl_axi_wr u_wr (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awaddr        (s_axi_awaddr),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wvalid        (s_axi_wvalid),
        .wready        (s_axi_wready),
        .bresp         (s_axi_bresp),
        .bvalid        (s_axi_bvalid),
        .bready        (s_axi_bready),
        .cmd           (cmd)
    );

    rst_ctrl_reg #(
        .NUM_RESETS (NUM_RESETS)
    ) u_reg (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cmd           (cmd),
        .reg_value     (reg_value)
    );

    rst_ctrl_axi_rd #(
        .NUM_RESETS (NUM_RESETS)
    ) u_rd (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rdata         (s_axi_rdata),
        .rresp         (s_axi_rresp),
        .rvalid        (s_axi_rvalid),
        .rready        (s_axi_rready),
        .reg_value     (reg_value)
    );

    assign reset_out = reg_value;

endmodule

`default_nettype wire

// File: rst_ctrl_asserts.sv
// AXI4-Lite protocol assertions, bound into the reset controller top level for simulation
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_asserts (
    input wire        s_axi_aclk,
    input wire        s_axi_aresetn,
    input wire        awready,
    input wire        wready,
    input wire        bvalid,
    input wire        bready,
    input wire        arready,
    input wire        rvalid,
    input wire        rready,
    input wire [31:0] rdata,
    input wire        cmd_valid
);

    int fail_count = 0;

    a_b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    // R payload frozen while the master stalls
    a_r_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            fail_count++;
            $error("rvalid or rdata changed while rready was low");
        end

    a_ready_in_reset: assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |-> !awready && !wready && !arready)
        else begin
            fail_count++;
            $error("ready signal high during reset");
        end

    a_cmd_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        cmd_valid |=> !cmd_valid)
        else begin
            fail_count++;
            $error("register command valid for two cycles");
        end

endmodule

bind rst_ctrl_top rst_ctrl_asserts u_asserts (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awready       (s_axi_awready),
    .wready        (s_axi_wready),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .arready       (s_axi_arready),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rdata         (s_axi_rdata),
    .cmd_valid     (u_wr.cmd.valid)
);

`default_nettype wire

// File: rst_ctrl_tb.sv
// Table-driven testbench for the reset controller, run as the simulation top with the file list
`timescale 1ns/10ps
`default_nettype none

module rst_ctrl_tb;

    localparam int NUM_RESETS   = 8;
    localparam int NUM_TESTS    = 12;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        logic                  is_write;
        logic [1:0]            offset;
        logic [31:0]           data;
        logic [1:0]            resp;
        logic [NUM_RESETS-1:0] value;
    } entry_t;

    logic                  s_axi_aclk = 1'b0;
    logic                  s_axi_aresetn;
    logic [31:0]           s_axi_awaddr;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [31:0]           s_axi_wdata;
    logic [3:0]            s_axi_wstrb;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [31:0]           s_axi_araddr;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [31:0]           s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    logic [NUM_RESETS-1:0] reset_out;

    entry_t      entries [NUM_TESTS];
    string       names [NUM_TESTS];
    int          num_entries = 0;
    int          errors = 0;
    logic [31:0] lcg_state = 32'hed3f_2b3c;

    rst_ctrl_top #(
        .NUM_RESETS (NUM_RESETS)
    ) u_dut (
        .*
    );

    always #10 s_axi_aclk = ~s_axi_aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input logic is_write, input logic [1:0] offset,
                             input logic [31:0] data, input logic [1:0] resp,
                             input logic [NUM_RESETS-1:0] value);
        names[num_entries] = name;
        entries[num_entries] = '{is_write, offset, data, resp, value};
        num_entries++;
    endtask

    // Address first, data after data_gap cycles (0 means together)
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data, input int data_gap,
                             input int b_gap, output logic [1:0] resp);
        bit aw_done;
        bit w_done;
        int n;
        aw_done = 1'b0;
        w_done  = 1'b0;
        n       = 0;
        @(posedge s_axi_aclk);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        if (data_gap == 0) begin
            s_axi_wdata  <= data;
            s_axi_wvalid <= 1'b1;
        end
        while (!(aw_done && w_done)) begin
            @(posedge s_axi_aclk);
            n++;
            if (s_axi_awvalid && s_axi_awready) begin
                aw_done = 1'b1;
                s_axi_awvalid <= 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_done = 1'b1;
                s_axi_wvalid <= 1'b0;
            end else if (!w_done && !s_axi_wvalid && n >= data_gap) begin
                s_axi_wdata  <= data;
                s_axi_wvalid <= 1'b1;
            end
        end
        repeat (b_gap) @(posedge s_axi_aclk);
        s_axi_bready <= 1'b1;
        do @(posedge s_axi_aclk); while (!(s_axi_bvalid && s_axi_bready));
        resp = s_axi_bresp;
        s_axi_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int r_gap, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge s_axi_aclk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do @(posedge s_axi_aclk); while (!(s_axi_arvalid && s_axi_arready));
        s_axi_arvalid <= 1'b0;
        repeat (r_gap) @(posedge s_axi_aclk);
        s_axi_rready <= 1'b1;
        do @(posedge s_axi_aclk); while (!(s_axi_rvalid && s_axi_rready));
        data = s_axi_rdata;
        resp = s_axi_rresp;
        s_axi_rready <= 1'b0;
    endtask

    // Watchdog sized from the table length
    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * 40) @(posedge s_axi_aclk);
        errors++;
        $display("Simulation timed out before all table entries completed");
        $display("Test finished with %0d errors", errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [1:0]  resp;
        logic [31:0] rdata_got;
        int          data_gap;
        int          b_gap;
        int          r_gap;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hf;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        // Expected values follow load, set and clear on the low eight bits
        add_entry("reset_read",        1'b0, 2'd0, 32'h0000_0000, rst_ctrl_pkg::resp_okay,   8'h00);
        add_entry("load_low",          1'b1, 2'd0, 32'h0000_00a5, rst_ctrl_pkg::resp_okay,   8'ha5);
        add_entry("load_upper_ignored", 1'b1, 2'd0, 32'hffff_ff3c, rst_ctrl_pkg::resp_okay,  8'h3c);
        add_entry("set_bits",          1'b1, 2'd1, 32'h0000_00c1, rst_ctrl_pkg::resp_okay,   8'hfd);
        add_entry("clear_bits",        1'b1, 2'd2, 32'h0000_0035, rst_ctrl_pkg::resp_okay,   8'hc8);
        add_entry("bad_offset",        1'b1, 2'd3, 32'h0000_00ff, rst_ctrl_pkg::resp_slverr, 8'hc8);
        add_entry("read_any_addr",     1'b0, 2'd3, 32'h0000_0000, rst_ctrl_pkg::resp_okay,   8'hc8);
        add_entry("set_upper_ignored", 1'b1, 2'd1, 32'habcd_1202, rst_ctrl_pkg::resp_okay,   8'hca);
        add_entry("clear_all",         1'b1, 2'd2, 32'h0000_00ff, rst_ctrl_pkg::resp_okay,   8'h00);
        add_entry("load_all",          1'b1, 2'd0, 32'h0000_01ff, rst_ctrl_pkg::resp_okay,   8'hff);
        add_entry("clear_one",         1'b1, 2'd2, 32'h0000_0080, rst_ctrl_pkg::resp_okay,   8'h7f);
        add_entry("bad_offset_zero",   1'b1, 2'd3, 32'h0000_0000, rst_ctrl_pkg::resp_slverr, 8'h7f);
        repeat (RESET_CYCLES) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            lcg_state = lcg_next(lcg_state);
            data_gap  = lcg_state[17:16];
            lcg_state = lcg_next(lcg_state);
            b_gap     = lcg_state[17:16];
            lcg_state = lcg_next(lcg_state);
            r_gap     = lcg_state[17:16];
            if (entries[i].is_write) begin
                axi_write({28'd0, entries[i].offset, 2'b00}, entries[i].data, data_gap, b_gap,
                          resp);
                check_value({names[i], " bresp"}, 32'(entries[i].resp), 32'(resp));
                repeat (2) @(posedge s_axi_aclk);
            end
            check_value({names[i], " reset_out"}, 32'(entries[i].value), 32'(reset_out));
            axi_read({28'd0, entries[i].offset, 2'b00}, r_gap, rdata_got, resp);
            check_value({names[i], " rdata"}, 32'(entries[i].value), rdata_got);
            check_value({names[i], " rresp"}, 32'(rst_ctrl_pkg::resp_okay), 32'(resp));
        end
        repeat (2) @(posedge s_axi_aclk);
        errors += u_dut.u_asserts.fail_count;
        $display("Test finished with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rst_ctrl.f
rst_ctrl_pkg.sv
rst_ctrl_axi_wr.sv
rst_ctrl_reg.sv
rst_ctrl_axi_rd.sv
rst_ctrl_top.sv
rst_ctrl_asserts.sv
rst_ctrl_tb.sv

// File: Bender.yml
package:
  name: rst_ctrl

sources:
  - rst_ctrl_pkg.sv
  - rst_ctrl_axi_wr.sv
  - rst_ctrl_reg.sv
  - rst_ctrl_axi_rd.sv
  - rst_ctrl_top.sv
  - target: test
    files:
      - rst_ctrl_asserts.sv
      - rst_ctrl_tb.sv
